//--- Bender.yml
package:
  name: control_unit

sources:
  - files:
      - src/isaPkg.sv
      - src/ctrlPkg.sv
      - src/phaseSequencer.sv
      - src/aluGroupDecoder.sv
      - src/loadStoreDecoder.sv
      - src/opxMultiplexer.sv
      - src/controlUnit.sv
  - target: test
    files:
      - dv/controlUnit_assert.sv
      - dv/controlUnitTb.sv

//--- build.f
src/isaPkg.sv
src/ctrlPkg.sv
src/phaseSequencer.sv
src/aluGroupDecoder.sv
src/loadStoreDecoder.sv
src/opxMultiplexer.sv
src/controlUnit.sv
dv/controlUnit_assert.sv
dv/controlUnitTb.sv

//--- dv/controlUnitTb.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnitTb;

	import isaPkg::*;
	import ctrlPkg::*;

	localparam int numFixed       = 14;
	localparam int numRows        = 20;
	localparam int watchdogCycles = numRows * 4 + 16 + 20;

	logic      CLK;
	logic      rst;
	instrWord  instrIn;
	cpuPhase   phase;
	ctrlBundle ctrl;
	addrBusSel addrBus;

	// Stimulus table
	string     rowName[numRows];
	instrWord  rowInstr[numRows];
	ctrlBundle rowExec[numRows];
	ctrlBundle rowCommit[numRows];
	addrBusSel rowAddr[numRows];

	int     errCount;
	int     testErrs;
	int     passCount;
	int     failCount;
	integer seed;

	controlUnit UUT (
		.CLK     (CLK),
		.rst     (rst),
		.instrIn (instrIn),
		.phase   (phase),
		.ctrl    (ctrl),
		.addrBus (addrBus)
	);

	always #2 CLK = ~CLK;

	////////////////////////////////////////////////////////////////////////////
	// Expected values from the decoding rules
	////////////////////////////////////////////////////////////////////////////

	function automatic instrWord makeInstr(instrGroup g, subOp op, argA a, argB b, jumpSrc j);
		instrWord w;
		w.group = g;
		w.op    = op;
		w.aSel  = a;
		w.bSel  = b;
		w.jSel  = j;
		w.rsvd  = 2'b00;
		return w;
	endfunction

	function automatic ctrlBundle expectCtrl(instrWord w, cpuPhase p);
		ctrlBundle c;
		logic rd;
		logic ex;
		logic cm;
		rd = (p == phDecode) || (p == phExecute);
		ex = (p == phExecute);
		cm = (p == phCommit);
		c  = idleBundle;
		if (w.group == groupAluLogic) begin
			c.aluOp    = (w.op <= aluCmp) ? w.op : aluMov; // Unknown ops act as a move
			c.regaAddr = w.aSel;
			c.regbAddr = w.bSel;
			c.regaEn   = rd;
			c.regbEn   = rd;
			c.aluLd    = ex;
			c.regaWen  = cm && (c.aluOp != aluCmp);
		end else if (w.group == groupLoadStore) begin
			c.regaAddr = w.aSel;
			c.regbAddr = w.bSel;
			if (w.op == ldsLoad) begin
				c.regbEn  = rd;
				c.regaDin = dinDataBus;
				c.regaWen = cm;
			end else if (w.op == ldsStore) begin
				c.regaEn     = rd;
				c.regbEn     = rd;
				c.aluLd      = ex;
				c.dataBusOen = ex;
			end else if (w.op == ldsPush || w.op == ldsPop) begin
				c.regbEn    = rd;
				c.aluOp     = aluAdd;
				c.aluaSrc   = aluaSrcConst;
				c.aluaConst = (w.op == ldsPush) ? constMinusOne : constOne;
				c.aluLd     = ex;
				c.regbWen   = cm;
			end
		end else if (w.group == groupJump) begin
			c.alubSrc  = alubSrcSel'(w.jSel);
			c.regbAddr = w.bSel;
		end
		return c;
	endfunction

	// System and jump follow the load/store request
	function automatic addrBusSel expectAddr(instrWord w);
		addrBusSel a;
		if (w.group == groupAluLogic) a = addrSp;
		else if (w.op == ldsLoad || w.op == ldsStore) a = addrRegB;
		else if (w.op == ldsPush || w.op == ldsPop) a = addrSp;
		else a = addrPc;
		return a;
	endfunction

	function automatic logic enablesOff(ctrlBundle c);
		return !(c.regaEn || c.regbEn || c.regaWen || c.regbWen || c.aluLd || c.dataBusOen);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	task automatic checkPhase(input string name, input cpuPhase exp, input cpuPhase act);
		if (act !== exp) begin
			$display("FAIL %s phase expected %0d actual %0d", name, exp, act);
			errCount++;
			testErrs++;
		end
	endtask

	task automatic checkCtrl(input string name, input string stage, input ctrlBundle exp,
		input ctrlBundle act);
		if (act !== exp) begin
			$display("FAIL %s %s ctrl expected %h actual %h", name, stage, exp, act);
			errCount++;
			testErrs++;
		end
	endtask

	task automatic checkAddr(input string name, input string stage, input addrBusSel exp,
		input addrBusSel act);
		if (act !== exp) begin
			$display("FAIL %s %s addrBus expected %0d actual %0d", name, stage, exp, act);
			errCount++;
			testErrs++;
		end
	endtask

	task automatic reportTest(input string name);
		if (testErrs == 0) begin
			passCount++;
			$display("PASS %s", name);
		end else begin
			failCount++;
			$display("Test %s had %0d errors", name, testErrs);
		end
	endtask

	task automatic setRow(input int idx, input string name, input instrWord w);
		rowName[idx]  = name;
		rowInstr[idx] = w;
	endtask

	task automatic fillTable();
		setRow(0, "alu mov", makeInstr(groupAluLogic, aluMov, 3'd1, 2'd2, 3'd0));
		setRow(1, "alu add", makeInstr(groupAluLogic, aluAdd, 3'd2, 2'd1, 3'd0));
		setRow(2, "alu sub", makeInstr(groupAluLogic, aluSub, 3'd3, 2'd3, 3'd0));
		setRow(3, "alu and", makeInstr(groupAluLogic, aluAnd, 3'd4, 2'd0, 3'd0));
		setRow(4, "alu or", makeInstr(groupAluLogic, aluOr, 3'd5, 2'd1, 3'd0));
		setRow(5, "alu xor", makeInstr(groupAluLogic, aluXor, 3'd6, 2'd2, 3'd0));
		setRow(6, "alu cmp", makeInstr(groupAluLogic, aluCmp, 3'd7, 2'd3, 3'd0));
		setRow(7, "lds load", makeInstr(groupLoadStore, ldsLoad, 3'd2, 2'd1, 3'd0));
		setRow(8, "lds store", makeInstr(groupLoadStore, ldsStore, 3'd5, 2'd2, 3'd0));
		setRow(9, "lds push", makeInstr(groupLoadStore, ldsPush, 3'd1, 2'd3, 3'd0));
		setRow(10, "lds pop", makeInstr(groupLoadStore, ldsPop, 3'd3, 2'd3, 3'd0));
		setRow(11, "system", makeInstr(groupSystem, 4'h2, 3'd4, 2'd1, 3'd3));
		setRow(12, "jump imm", makeInstr(groupJump, 4'h0, 3'd0, 2'd2, 3'd1));
		setRow(13, "jump pc", makeInstr(groupJump, 4'h5, 3'd6, 2'd1, 3'd3));
		for (int i = numFixed; i < numRows; i++) begin
			rowName[i]  = $sformatf("random %0d", i - numFixed);
			rowInstr[i] = instrWord'(16'($random(seed)));
		end
		for (int i = 0; i < numRows; i++) begin
			rowExec[i]   = expectCtrl(rowInstr[i], phExecute);
			rowCommit[i] = expectCtrl(rowInstr[i], phCommit);
			rowAddr[i]   = expectAddr(rowInstr[i]);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		CLK       = 1'b0;
		rst       = 1'b1;
		instrIn   = '0;
		errCount  = 0;
		passCount = 0;
		failCount = 0;
		seed      = 32'h1bd98ee4;
		fillTable();

		repeat (16) @(negedge CLK);
		testErrs = 0;
		checkPhase("reset", phFetch, phase);
		checkCtrl("reset", "fetch", idleBundle, ctrl);
		checkAddr("reset", "fetch", addrPc, addrBus);
		reportTest("reset");
		rst     = 1'b0;
		instrIn = rowInstr[0];

		// Back to back with no gap between instructions
		for (int i = 0; i < numRows; i++) begin
			testErrs = 0;
			@(negedge CLK);
			checkPhase(rowName[i], phDecode, phase);
			checkCtrl(rowName[i], "decode", expectCtrl(rowInstr[i], phDecode), ctrl);
			checkAddr(rowName[i], "decode", addrPc, addrBus);
			@(negedge CLK);
			checkPhase(rowName[i], phExecute, phase);
			checkCtrl(rowName[i], "execute", rowExec[i], ctrl);
			checkAddr(rowName[i], "execute", rowAddr[i], addrBus);
			@(negedge CLK);
			checkPhase(rowName[i], phCommit, phase);
			checkCtrl(rowName[i], "commit", rowCommit[i], ctrl);
			checkAddr(rowName[i], "commit", rowAddr[i], addrBus);
			@(negedge CLK);
			checkPhase(rowName[i], phFetch, phase);
			if (!enablesOff(ctrl)) begin
				$display("FAIL %s fetch enables expected all zero actual ctrl %h",
					rowName[i], ctrl);
				errCount++;
				testErrs++;
			end
			checkAddr(rowName[i], "fetch", rowAddr[i], addrBus);
			if (i + 1 < numRows) instrIn = rowInstr[i + 1];
			reportTest(rowName[i]);
		end

		$display("Tests %0d passed %0d failed %0d errors %0d assertion failures %0d",
			passCount + failCount, passCount, failCount, errCount, UUT.uAssert.violations);
		if (failCount == 0 && errCount == 0 && UUT.uAssert.violations == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		repeat (watchdogCycles) @(posedge CLK);
		$display("Watchdog expired, the run timed out before all tests finished");
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/controlUnit_assert.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnitAssert (
	input wire                CLK,
	input wire                rst,
	input ctrlPkg::cpuPhase   phase,
	input ctrlPkg::ctrlBundle ctrl
);

	import ctrlPkg::*;

	int violations = 0;

	////////////////////////////////////////////////////////////////////////////
	// Phase and enable rules
	////////////////////////////////////////////////////////////////////////////

	phaseOrder: assert property (@(posedge CLK) disable iff (rst)
		1'b1 |=> phase == cpuPhase'($past(phase) + 2'd1))
		else begin
			$error("phase did not step in order");
			violations++;
		end

	writeInCommit: assert property (@(posedge CLK) disable iff (rst)
		(ctrl.regaWen || ctrl.regbWen) |-> phase == phCommit)
		else begin
			$error("write enable outside commit");
			violations++;
		end

	loadInExecute: assert property (@(posedge CLK) disable iff (rst)
		ctrl.aluLd |-> phase == phExecute)
		else begin
			$error("aluLd outside execute");
			violations++;
		end

	fetchQuiet: assert property (@(posedge CLK) disable iff (rst)
		phase == phFetch |-> !(ctrl.regaEn || ctrl.regbEn || ctrl.regaWen ||
			ctrl.regbWen || ctrl.aluLd || ctrl.dataBusOen))
		else begin
			$error("enable set during fetch");
			violations++;
		end

endmodule

bind controlUnit controlUnitAssert uAssert (
	.CLK   (CLK),
	.rst   (rst),
	.phase (phase),
	.ctrl  (ctrl)
);

`default_nettype wire

//--- src/aluGroupDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module aluGroupDecoder (
	input  isaPkg::instrWord   instr,
	input  ctrlPkg::cpuPhase   phase,
	output ctrlPkg::ctrlBundle ctrl,
	output ctrlPkg::addrBusSel addrReq
);

	import isaPkg::*;
	import ctrlPkg::*;

	logic readPhase;
	logic execPhase;
	logic commitPhase;
	subOp opSel;

	assign readPhase   = (phase == phDecode) || (phase == phExecute);
	assign execPhase   = (phase == phExecute);
	assign commitPhase = (phase == phCommit);

	// Unknown sub-opcodes fall back to a move
	always_comb begin
		case (instr.op)
			aluMov,
			aluAdd,
			aluSub,
			aluAnd,
			aluOr,
			aluXor,
			aluCmp:  opSel = instr.op;
			default: opSel = aluMov;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Bundle
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		ctrl = idleBundle;

		ctrl.aluOp    = opSel;
		ctrl.aluaSrc  = aluaSrcRegA; // A operand from register A
		ctrl.alubSrc  = alubRegB;
		ctrl.regaDin  = dinAluResult;
		ctrl.regaAddr = instr.aSel; // Destination
		ctrl.regbAddr = instr.bSel;

		// Phase gating
		ctrl.regaEn  = readPhase;
		ctrl.regbEn  = readPhase;
		ctrl.aluLd   = execPhase;
		ctrl.regaWen = commitPhase && (opSel != aluCmp); // Compare only sets flags
		ctrl.regbWen = 1'b0;
	end

	assign addrReq = addrSp;

endmodule

`default_nettype wire

//--- src/controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnit (
	input  wire                CLK,
	input  wire                rst,
	input  isaPkg::instrWord   instrIn,
	output ctrlPkg::cpuPhase   phase,
	output ctrlPkg::ctrlBundle ctrl,
	output ctrlPkg::addrBusSel addrBus
);

	import isaPkg::*;
	import ctrlPkg::*;

	instrWord  instr;
	ctrlBundle aluCtrl;
	ctrlBundle ldsCtrl;
	addrBusSel aluAddrReq;
	addrBusSel ldsAddrReq;

	phaseSequencer uSeq (
		.CLK     (CLK),
		.rst     (rst),
		.instrIn (instrIn),
		.phase   (phase),
		.instr   (instr)
	);

	////////////////////////////////////////////////////////////////////////////
	// Group decoders, side by side
	////////////////////////////////////////////////////////////////////////////

	aluGroupDecoder uAluDec (
		.instr   (instr),
		.phase   (phase),
		.ctrl    (aluCtrl),
		.addrReq (aluAddrReq)
	);

	loadStoreDecoder uLdsDec (
		.instr   (instr),
		.phase   (phase),
		.ctrl    (ldsCtrl),
		.addrReq (ldsAddrReq)
	);

	opxMultiplexer uOpx (
		.CLK        (CLK),
		.rst        (rst),
		.instr      (instr),
		.phase      (phase),
		.aluCtrl    (aluCtrl),
		.ldsCtrl    (ldsCtrl),
		.aluAddrReq (aluAddrReq),
		.ldsAddrReq (ldsAddrReq),
		.ctrl       (ctrl),
		.addrBus    (addrBus)
	);

endmodule

`default_nettype wire

//--- src/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

	typedef enum logic [1:0] {
		phFetch   = 2'd0,
		phDecode  = 2'd1,
		phExecute = 2'd2,
		phCommit  = 2'd3
	} cpuPhase;

	////////////////////////////////////////////////////////////////////////////
	// Source selects
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		constOne      = 2'd0,
		constZero     = 2'd1,
		constTwo      = 2'd2,
		constMinusOne = 2'd3
	} aluaConstSel;

	typedef enum logic {
		aluaSrcRegA  = 1'b0,
		aluaSrcConst = 1'b1
	} aluaSrcSel;

	typedef enum logic [2:0] {
		alubRegB    = 3'd0,
		alubImm     = 3'd1,
		alubDataBus = 3'd2,
		alubPc      = 3'd3,
		alubConst   = 3'd4
	} alubSrcSel;

	typedef enum logic [1:0] {
		dinAluResult = 2'd0,
		dinDataBus   = 2'd1
	} regaDinSel;

	typedef enum logic [1:0] {
		dbusAluResult = 2'd0,
		dbusRegB      = 2'd1
	} dataBusSel;

	typedef enum logic [1:0] {
		addrPc   = 2'd0,
		addrRegB = 2'd1,
		addrSp   = 2'd2
	} addrBusSel;

	////////////////////////////////////////////////////////////////////////////
	// Control bundle
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic         regaEn;
		logic         regbEn;
		logic         regaWen;
		logic         regbWen;
		isaPkg::subOp aluOp;
		logic         aluLd;
		aluaConstSel  aluaConst;
		aluaSrcSel    aluaSrc;
		alubSrcSel    alubSrc;
		regaDinSel    regaDin;
		isaPkg::argA  regaAddr;
		isaPkg::argB  regbAddr;
		dataBusSel    dataBus;
		logic         dataBusOen;
	} ctrlBundle;

	// Nothing enabled, ALU left on a move
	localparam ctrlBundle idleBundle = '{
		regaEn:     1'b0,
		regbEn:     1'b0,
		regaWen:    1'b0,
		regbWen:    1'b0,
		aluOp:      isaPkg::aluMov,
		aluLd:      1'b0,
		aluaConst:  constOne,
		aluaSrc:    aluaSrcRegA,
		alubSrc:    alubRegB,
		regaDin:    dinAluResult,
		regaAddr:   3'd0,
		regbAddr:   2'd0,
		dataBus:    dbusAluResult,
		dataBusOen: 1'b0
	};

endpackage

`default_nettype wire

//--- src/isaPkg.sv
`default_nettype none

package isaPkg;

	////////////////////////////////////////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		groupSystem    = 2'd0,
		groupLoadStore = 2'd1,
		groupJump      = 2'd2,
		groupAluLogic  = 2'd3
	} instrGroup;

	typedef logic [3:0] subOp;
	typedef logic [2:0] argA;
	typedef logic [1:0] argB;
	typedef logic [2:0] jumpSrc;

	typedef struct packed {
		instrGroup  group; // Bits 15..14
		subOp       op;    // Bits 13..10
		argA        aSel;  // Bits 9..7
		argB        bSel;  // Bits 6..5
		jumpSrc     jSel;  // Bits 4..2, jump group only
		logic [1:0] rsvd;  // Bits 1..0
	} instrWord;

	////////////////////////////////////////////////////////////////////////////
	// Sub-opcodes
	////////////////////////////////////////////////////////////////////////////

	// Arithmetic/logic group, all but compare write register A
	localparam subOp aluMov = 4'h0;
	localparam subOp aluAdd = 4'h1;
	localparam subOp aluSub = 4'h2;
	localparam subOp aluAnd = 4'h3;
	localparam subOp aluOr  = 4'h4;
	localparam subOp aluXor = 4'h5;
	localparam subOp aluCmp = 4'h6; // Flags only

	// Load/store group
	localparam subOp ldsLoad  = 4'h0;
	localparam subOp ldsStore = 4'h1;
	localparam subOp ldsPush  = 4'h2;
	localparam subOp ldsPop   = 4'h3;

endpackage

`default_nettype wire

//--- src/loadStoreDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module loadStoreDecoder (
	input  isaPkg::instrWord   instr,
	input  ctrlPkg::cpuPhase   phase,
	output ctrlPkg::ctrlBundle ctrl,
	output ctrlPkg::addrBusSel addrReq
);

	import isaPkg::*;
	import ctrlPkg::*;

	logic readPhase;
	logic execPhase;
	logic commitPhase;

	assign readPhase   = (phase == phDecode) || (phase == phExecute);
	assign execPhase   = (phase == phExecute);
	assign commitPhase = (phase == phCommit);

	////////////////////////////////////////////////////////////////////////////
	// Bundle and address request
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		ctrl          = idleBundle;
		ctrl.regaAddr = instr.aSel;
		ctrl.regbAddr = instr.bSel;
		addrReq       = addrPc;

		case (instr.op)
			ldsLoad: begin
				ctrl.regbEn  = readPhase; // Address from register B
				ctrl.regaDin = dinDataBus;
				ctrl.regaWen = commitPhase;
				addrReq      = addrRegB;
			end

			ldsStore: begin
				ctrl.regaEn     = readPhase;
				ctrl.regbEn     = readPhase;
				ctrl.aluOp      = aluMov; // Register A passes through the ALU
				ctrl.aluaSrc    = aluaSrcRegA;
				ctrl.aluLd      = execPhase;
				ctrl.dataBus    = dbusAluResult;
				ctrl.dataBusOen = execPhase;
				addrReq         = addrRegB;
			end

			ldsPush,
			ldsPop: begin
				ctrl.regbEn    = readPhase; // Register B holds the pointer
				ctrl.aluOp     = aluAdd;
				ctrl.aluaSrc   = aluaSrcConst;
				ctrl.aluaConst = (instr.op == ldsPush) ? constMinusOne : constOne;
				ctrl.alubSrc   = alubRegB;
				ctrl.aluLd     = execPhase;
				ctrl.regbWen   = commitPhase;
				addrReq        = addrSp;
			end

			default: begin
				addrReq = addrPc;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- src/opxMultiplexer.sv
`timescale 1ns/100ps
`default_nettype none

module opxMultiplexer (
	input  wire                CLK,
	input  wire                rst,
	input  isaPkg::instrWord   instr,
	input  ctrlPkg::cpuPhase   phase,
	input  ctrlPkg::ctrlBundle aluCtrl,
	input  ctrlPkg::ctrlBundle ldsCtrl,
	input  ctrlPkg::addrBusSel aluAddrReq,
	input  ctrlPkg::addrBusSel ldsAddrReq,
	output ctrlPkg::ctrlBundle ctrl,
	output ctrlPkg::addrBusSel addrBus
);

	import isaPkg::*;
	import ctrlPkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Bundle select
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		ctrl = idleBundle;

		case (instr.group)
			groupSystem: begin
				ctrl = idleBundle;
			end

			groupLoadStore: begin
				ctrl = ldsCtrl;
			end

			groupJump: begin
				// Branch target operands come straight from the instruction
				ctrl.alubSrc  = alubSrcSel'(instr.jSel);
				ctrl.regbAddr = instr.bSel;
			end

			groupAluLogic: begin
				ctrl = aluCtrl;
			end

			default: begin
				ctrl = idleBundle;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Address bus select
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			addrBus <= addrPc;
		end else if (phase == phFetch) begin
			addrBus <= addrPc; // Program counter during decode
		end else begin
			case (instr.group)
				groupAluLogic: addrBus <= aluAddrReq;
				groupLoadStore,
				groupSystem,
				groupJump:     addrBus <= ldsAddrReq;
				default:       addrBus <= ldsAddrReq;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/phaseSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module phaseSequencer (
	input  wire               CLK,
	input  wire               rst,
	input  isaPkg::instrWord  instrIn,
	output ctrlPkg::cpuPhase  phase,
	output isaPkg::instrWord  instr
);

	import ctrlPkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Phase rotation
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			phase <= phFetch;
		end else begin
			phase <= cpuPhase'(phase + 2'd1); // Commit wraps to fetch
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Instruction register
	////////////////////////////////////////////////////////////////////////////

	// Held through decode, execute and commit
	always_ff @(posedge CLK) begin
		if (rst) begin
			instr <= '0; // Decodes as a system instruction
		end else if (phase == phFetch) begin
			instr <= instrIn;
		end
	end

endmodule

`default_nettype wire
